//--- rtl/usb_defines.svh
// usb list unpack defines: address, word, descriptor and service ratio widths
`ifndef USB_DEFINES_SVH
`define USB_DEFINES_SVH

// descriptor address, 16-byte aligned, bits 31:4 of the byte address
`define USB_ADDR_W 28

// dma word width
`define USB_WORD_W 32

// dma words per ED or TD
`define USB_DESC_WORDS 4

// control/bulk service ratio field (HcControl.CBSR)
`define USB_CBSR_W 2

`endif

//--- rtl/usb_ohci_pkg.sv
// usb ohci memory formats: ED and TD layouts as they arrive from the dma
`include "usb_defines.svh"

package usb_ohci_pkg;

    // control word bit that tells the host controller to skip the ED
    localparam int unsigned ed_skip_bit = 14;

    // HeadP dword of an ED
    typedef struct packed {
        logic [`USB_ADDR_W-1:0] addr;    // first TD of the queue
        logic [1:0]             zero;
        logic                   carry;   // toggle carry
        logic                   halted;  // set by hc on error
    } head_p_t;

    // word 0 sits in the low 32 bits, word 3 in the top
    typedef struct packed {
        logic [`USB_ADDR_W-1:0] next_ed;
        logic [3:0]             next_ed_rsvd;
        head_p_t                head_p;
        logic [`USB_ADDR_W-1:0] tail_p;  // HeadP == TailP means no TD queued
        logic [3:0]             tail_p_rsvd;
        logic [`USB_WORD_W-1:0] control; // fa, en, dir, speed, skip, format, mps
    } ed_t;

    // general TD
    typedef struct packed {
        logic [`USB_WORD_W-1:0] be;      // buffer end
        logic [`USB_ADDR_W-1:0] next_td;
        logic [3:0]             next_td_rsvd;
        logic [`USB_WORD_W-1:0] cbp;     // current buffer pointer
        logic [`USB_WORD_W-1:0] control;
    } td_t;

endpackage

//--- rtl/usb_list_pkg.sv
// usb list control types: kind of list being walked and kind of fetch in flight
package usb_list_pkg;

    // list the walk was started on
    typedef enum logic [1:0] {
        list_control   = 2'd0,
        list_bulk      = 2'd1,
        list_interrupt = 2'd2,
        list_iso       = 2'd3
    } list_kind_e;

    // what the list service is asked to fetch
    typedef enum logic {
        fetch_ed = 1'b0,
        fetch_td = 1'b1
    } fetch_kind_e;

endpackage

//--- rtl/usb_desc_assembler.sv
// usb descriptor assembler gathering four dma words into one ED or TD
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_desc_assembler #(
    parameter type desc_t = logic [`USB_DESC_WORDS*`USB_WORD_W-1:0]
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [`USB_WORD_W-1:0] word_i,
    input  logic                  word_valid_i,
    output logic                  word_ready_o,
    output desc_t                 desc_o,
    output logic                  desc_valid_o,
    input  logic                  take_i
);

    localparam int unsigned idx_w = $clog2(`USB_DESC_WORDS);

    logic [idx_w-1:0]                        idx_q;      // next slot to fill
    logic [`USB_DESC_WORDS*`USB_WORD_W-1:0] slots_q;    // payload
    logic                                    full_q;
    logic                                    accept;

    assign word_ready_o = !full_q;                  // stall while descriptor waits
    assign accept       = word_valid_i && word_ready_o;

    // word index and full flag
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            idx_q  <= '0;
            full_q <= 1'b0;
        end else begin
            if (accept) begin
                idx_q <= idx_q + 1'b1;                 // wraps after last word
                if (idx_q == idx_w'(`USB_DESC_WORDS - 1)) begin
                    full_q <= 1'b1;                    // valid from next cycle
                end
            end
            if (take_i) begin
                full_q <= 1'b0;
            end
        end
    end

    // word n lands in slot n with word 0 lowest
    always_ff @(posedge clk_i) begin
        if (accept) begin
            slots_q[idx_q*`USB_WORD_W +: `USB_WORD_W] <= word_i;
        end
    end

    assign desc_o       = desc_t'(slots_q);
    assign desc_valid_o = full_q;

endmodule

//--- rtl/usb_ed_queue.sv
// usb ED queue: firstin is being served while secondin holds the prefetched ED
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_ed_queue import usb_ohci_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  ed_t                    ed_i,
    input  logic [`USB_ADDR_W-1:0] ed_addr_i,
    input  logic                   load_i,
    input  logic                   pop_i,
    output ed_t                    firstin_o,
    output logic [`USB_ADDR_W-1:0] firstin_addr_o,
    output logic                   firstin_valid_o,
    output ed_t                    secondin_o,
    output logic                   secondin_empty_o
);

    ed_t                    first_q;
    ed_t                    second_q;
    logic [`USB_ADDR_W-1:0] first_addr_q;
    logic [`USB_ADDR_W-1:0] second_addr_q;
    logic                   first_valid_q;
    logic                   second_valid_q;
    logic                   move_q;       // pop seen last cycle
    logic                   move;
    logic                   load_first;
    logic                   load_second;

    assign move        = move_q && second_valid_q;
    // only an empty queue loads straight into firstin
    // during a move secondin is still occupied, so the load goes behind it
    assign load_first  = load_i && !first_valid_q && !second_valid_q;
    assign load_second = load_i && (first_valid_q || second_valid_q);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            first_valid_q  <= 1'b0;
            second_valid_q <= 1'b0;
            move_q         <= 1'b0;
        end else begin
            move_q <= pop_i;
            if (pop_i) begin
                first_valid_q <= 1'b0;            // retire firstin
            end else if (move || load_first) begin
                first_valid_q <= 1'b1;
            end
            if (move) begin
                second_valid_q <= 1'b0;           // secondin moved up
            end
            if (load_second) begin
                second_valid_q <= 1'b1;           // wins over the move clear
            end
        end
    end

    // ED payload and its address travel together
    always_ff @(posedge clk_i) begin
        if (move) begin
            first_q      <= second_q;
            first_addr_q <= second_addr_q;
        end else if (load_first) begin
            first_q      <= ed_i;
            first_addr_q <= ed_addr_i;
        end
        if (load_second) begin
            second_q      <= ed_i;
            second_addr_q <= ed_addr_i;
        end
    end

    assign firstin_o        = first_q;
    assign firstin_addr_o   = first_addr_q;
    assign firstin_valid_o  = first_valid_q;
    assign secondin_o       = second_q;
    assign secondin_empty_o = !second_valid_q;

endmodule

//--- rtl/usb_cb_ratio_counter.sv
// usb control/bulk ratio counter: flags when cbsr+1 control TDs have been served
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_cb_ratio_counter (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`USB_CBSR_W-1:0] cbsr_i,
    input  logic                   served_control_i,
    input  logic                   served_bulk_i,
    input  logic                   restart_i,
    output logic                   ratio_reached_o
);

    logic [`USB_CBSR_W:0] count_q;   // one bit wider, holds cbsr+1
    logic [`USB_CBSR_W:0] limit;

    assign limit           = {1'b0, cbsr_i} + 1'b1;
    assign ratio_reached_o = (count_q == limit);

    always_ff @(posedge clk_i) begin
        if (rst_i || restart_i || served_bulk_i) begin
            count_q <= '0;                         // bulk turn resets the ratio
        end else if (served_control_i && !ratio_reached_o) begin
            count_q <= count_q + 1'b1;             // saturates at the limit
        end
    end

endmodule

//--- rtl/usb_unpack_descriptors.sv
// usb descriptor unpacker: picks the next fetch, steers dma words, runs the ED exit sequence
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_unpack_descriptors import usb_ohci_pkg::*; import usb_list_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   list_start_i,
    input  logic [`USB_ADDR_W-1:0] list_head_i,
    input  list_kind_e             list_kind_i,
    output logic                   next_valid_o,
    output fetch_kind_e            next_kind_o,
    output logic [`USB_ADDR_W-1:0] next_address_o,
    input  logic                   next_ready_i,
    input  logic                   dma_valid_i,
    output logic                   dma_ready_o,
    output logic                   ed_word_valid_o,
    input  logic                   ed_word_ready_i,
    input  logic                   ed_valid_i,
    output logic                   ed_take_o,
    output logic [`USB_ADDR_W-1:0] ed_addr_o,
    output logic                   td_word_valid_o,
    input  logic                   td_word_ready_i,
    input  ed_t                    firstin_i,
    input  logic [`USB_ADDR_W-1:0] firstin_addr_i,
    input  logic                   firstin_valid_i,
    input  logic                   secondin_empty_i,
    output logic                   pop_o,
    input  td_t                    td_i,
    input  logic                   td_valid_i,
    output logic                   td_take_o,
    output logic                   processed_valid_o,
    output logic [`USB_ADDR_W-1:0] processed_ed_addr_o,
    output logic [`USB_WORD_W-1:0] processed_head_p_o,
    output logic [`USB_ADDR_W-1:0] current_ed_o,
    output logic                   current_ed_valid_o,
    output logic                   list_done_o,
    output logic                   served_control_o,
    output logic                   served_bulk_o,
    output logic                   restart_o
);

    typedef enum logic [1:0] {st_idle, st_req, st_data} fetch_state_e;

    fetch_state_e           state_q;
    fetch_kind_e            kind_q;      // kind of the fetch in flight
    logic [`USB_ADDR_W-1:0] addr_q;
    list_kind_e             list_kind_q;
    logic [`USB_WORD_W-1:0] head_p_q;    // write-back value
    logic                   busy_q;      // firstin already in service
    logic                   succ_q;      // successor of firstin requested
    logic                   proc_q;
    logic                   cur_q;
    logic                   pop_q;
    logic                   inactive;
    logic                   want_ed;
    logic                   want_td;
    logic                   skip_go;
    logic                   fetch_done;

    // skip, halted and empty tests on firstin
    assign inactive = firstin_i.control[ed_skip_bit] || firstin_i.head_p.halted
                   || (firstin_i.head_p.addr == firstin_i.tail_p);
    assign skip_go  = firstin_valid_i && !busy_q && inactive;
    // prefetch the next ED first, then the head TD
    assign want_ed  = firstin_valid_i && secondin_empty_i && !succ_q && !pop_q
                   && (firstin_i.next_ed != '0);
    assign want_td  = firstin_valid_i && !busy_q && !inactive && !want_ed;
    assign fetch_done = (kind_q == fetch_ed) ? ed_valid_i : td_valid_i;

    // fetch sequencer, one fetch in flight
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= st_idle;
            busy_q  <= 1'b0;
            succ_q  <= 1'b0;
        end else begin
            if (pop_q) begin
                busy_q <= 1'b0;
                succ_q <= 1'b0;
            end
            if (skip_go) begin
                busy_q <= 1'b1;
            end
            case (state_q)
                st_idle: begin
                    if (list_start_i || want_ed || want_td) begin
                        state_q <= st_req;
                    end
                    if (!list_start_i && want_ed) begin
                        succ_q <= 1'b1;
                    end
                    if (!list_start_i && want_td) begin
                        busy_q <= 1'b1;
                    end
                end
                st_req: begin
                    if (next_ready_i) begin
                        state_q <= st_data;           // fields held until here
                    end
                end
                default: begin
                    if (fetch_done) begin
                        state_q <= st_idle;           // descriptor complete
                    end
                end
            endcase
        end
    end

    // request fields are only loaded while idle
    always_ff @(posedge clk_i) begin
        if (state_q == st_idle) begin
            if (list_start_i) begin
                kind_q      <= fetch_ed;
                addr_q      <= list_head_i;
                list_kind_q <= list_kind_i;
            end else if (want_ed) begin
                kind_q <= fetch_ed;
                addr_q <= firstin_i.next_ed;
            end else begin
                kind_q <= fetch_td;
                addr_q <= firstin_i.head_p.addr;
            end
        end
        if (td_valid_i) begin
            // new HeadP: served TD's next_td, carry and halted unchanged
            head_p_q <= {td_i.next_td, 2'b00, firstin_i.head_p.carry, firstin_i.head_p.halted};
        end
    end

    // exit sequence: served -> processed -> current ED -> pop
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            proc_q <= 1'b0;
            cur_q  <= 1'b0;
            pop_q  <= 1'b0;
        end else begin
            proc_q <= td_valid_i;
            cur_q  <= proc_q || skip_go;        // skipped ED enters here
            pop_q  <= cur_q;
        end
    end

    assign next_valid_o   = (state_q == st_req);
    assign next_kind_o    = kind_q;
    assign next_address_o = addr_q;

    // dma path selector
    assign ed_word_valid_o = dma_valid_i && (state_q == st_data) && (kind_q == fetch_ed);
    assign td_word_valid_o = dma_valid_i && (state_q == st_data) && (kind_q == fetch_td);
    assign dma_ready_o     = (state_q == st_data)
                          && ((kind_q == fetch_ed) ? ed_word_ready_i : td_word_ready_i);

    assign ed_take_o = ed_valid_i;               // queue loads right away
    assign ed_addr_o = addr_q;
    assign td_take_o = td_valid_i;

    assign processed_valid_o   = proc_q;
    assign processed_ed_addr_o = firstin_addr_i;
    assign processed_head_p_o  = head_p_q;
    assign current_ed_o        = firstin_i.next_ed;
    assign current_ed_valid_o  = cur_q;
    assign pop_o               = pop_q;
    assign list_done_o         = pop_q && (firstin_i.next_ed == '0) && secondin_empty_i;

    // served TD counts toward the control/bulk ratio
    assign served_control_o = td_valid_i && (list_kind_q == list_control);
    assign served_bulk_o    = td_valid_i && (list_kind_q == list_bulk);
    assign restart_o        = list_start_i;

endmodule

//--- rtl/usb_list_unpack_top.sv
// usb list unpack top: ED/TD assemblers, ED queue, unpacker and ratio counter
`timescale 1ns/1ps
`include "usb_defines.svh"

module usb_list_unpack_top import usb_ohci_pkg::*; import usb_list_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`USB_CBSR_W-1:0] cbsr_i,
    input  logic                   list_start_i,
    input  logic [`USB_ADDR_W-1:0] list_head_i,
    input  list_kind_e             list_kind_i,
    output logic                   next_valid_o,
    output fetch_kind_e            next_kind_o,
    output logic [`USB_ADDR_W-1:0] next_address_o,
    input  logic                   next_ready_i,
    input  logic [`USB_WORD_W-1:0] dma_data_i,
    input  logic                   dma_valid_i,
    output logic                   dma_ready_o,
    output logic                   processed_valid_o,
    output logic [`USB_ADDR_W-1:0] processed_ed_addr_o,
    output logic [`USB_WORD_W-1:0] processed_head_p_o,
    output logic [`USB_ADDR_W-1:0] current_ed_o,
    output logic                   current_ed_valid_o,
    output logic                   list_done_o,
    output logic                   ratio_reached_o
);

    // ED path
    logic                   ed_word_valid;
    logic                   ed_word_ready;
    ed_t                    ed_desc;
    logic                   ed_valid;
    logic                   ed_take;
    logic [`USB_ADDR_W-1:0] ed_addr;
    // TD path
    logic                   td_word_valid;
    logic                   td_word_ready;
    td_t                    td_desc;
    logic                   td_valid;
    logic                   td_take;
    // queue status
    ed_t                    firstin;
    logic [`USB_ADDR_W-1:0] firstin_addr;
    logic                   firstin_valid;
    logic                   secondin_empty;
    logic                   pop;
    // ratio counter events
    logic                   served_control;
    logic                   served_bulk;
    logic                   restart;

    usb_desc_assembler #(.desc_t(ed_t)) u_ed_asm (
        .clk_i, .rst_i,
        .word_i       (dma_data_i),
        .word_valid_i (ed_word_valid),
        .word_ready_o (ed_word_ready),
        .desc_o       (ed_desc),
        .desc_valid_o (ed_valid),
        .take_i       (ed_take)
    );

    usb_desc_assembler #(.desc_t(td_t)) u_td_asm (
        .clk_i, .rst_i,
        .word_i       (dma_data_i),
        .word_valid_i (td_word_valid),
        .word_ready_o (td_word_ready),
        .desc_o       (td_desc),
        .desc_valid_o (td_valid),
        .take_i       (td_take)
    );

    usb_ed_queue u_ed_queue (
        .clk_i, .rst_i,
        .ed_i             (ed_desc),
        .ed_addr_i        (ed_addr),
        .load_i           (ed_take),        // the assembler's take is the load
        .pop_i            (pop),
        .firstin_o        (firstin),
        .firstin_addr_o   (firstin_addr),
        .firstin_valid_o  (firstin_valid),
        .secondin_o       (),
        .secondin_empty_o (secondin_empty)
    );

    usb_unpack_descriptors u_unpack (
        .clk_i, .rst_i,
        .list_start_i, .list_head_i, .list_kind_i,
        .next_valid_o, .next_kind_o, .next_address_o, .next_ready_i,
        .dma_valid_i, .dma_ready_o,
        .ed_word_valid_o  (ed_word_valid),
        .ed_word_ready_i  (ed_word_ready),
        .ed_valid_i       (ed_valid),
        .ed_take_o        (ed_take),
        .ed_addr_o        (ed_addr),
        .td_word_valid_o  (td_word_valid),
        .td_word_ready_i  (td_word_ready),
        .firstin_i        (firstin),
        .firstin_addr_i   (firstin_addr),
        .firstin_valid_i  (firstin_valid),
        .secondin_empty_i (secondin_empty),
        .pop_o            (pop),
        .td_i             (td_desc),
        .td_valid_i       (td_valid),
        .td_take_o        (td_take),
        .processed_valid_o, .processed_ed_addr_o, .processed_head_p_o,
        .current_ed_o, .current_ed_valid_o, .list_done_o,
        .served_control_o (served_control),
        .served_bulk_o    (served_bulk),
        .restart_o        (restart)
    );

    usb_cb_ratio_counter u_cb_ratio (
        .clk_i, .rst_i, .cbsr_i,
        .served_control_i (served_control),
        .served_bulk_i    (served_bulk),
        .restart_i        (restart),
        .ratio_reached_o
    );

endmodule

//--- tb/usb_clk_gen.sv
// usb testbench clock generator: free running clock with a fixed period
`timescale 1ns/1ps

module usb_clk_gen #(
    parameter int period_ns = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;                                // known level at time zero
    end

    always #(period_ns / 2) clk_o = ~clk_o;         // half period per phase

endmodule

//--- tb/usb_list_unpack_assert.sv
// usb list unpack protocol checker for the fetch request, exit sequence and dma gating
`timescale 1ns/1ps

module usb_list_unpack_assert (
    input logic        clk_i,
    input logic        rst_i,
    input logic        next_valid_o,
    input logic        next_kind_o,
    input logic [27:0] next_address_o,
    input logic        next_ready_i,
    input logic        dma_ready_o,
    input logic        processed_valid_o,
    input logic        current_ed_valid_o
);

    int unsigned fail_cnt = 0;                      // failed assertion count

    // a waiting request keeps its kind and address
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        next_valid_o && !next_ready_i |=> next_valid_o && $stable(next_kind_o)
            && $stable(next_address_o))
        else begin
            fail_cnt++;
            $error("fetch request changed while waiting");
        end

    // write-back is followed by the current ED update
    proc_then_cur: assert property (@(posedge clk_i) disable iff (rst_i)
        processed_valid_o |=> current_ed_valid_o)
        else begin
            fail_cnt++;
            $error("no current ED pulse after write-back");
        end

    // dma words flow only once the request is accepted
    no_dma_during_req: assert property (@(posedge clk_i) disable iff (rst_i)
        !(dma_ready_o && next_valid_o))
        else begin
            fail_cnt++;
            $error("dma ready while fetch request waits");
        end

endmodule

bind usb_list_unpack_top usb_list_unpack_assert u_list_assert (.*);

//--- tb/tb_usb_list_unpack.sv
// usb list unpack testbench driving golden lists through a memory model and checking results
`timescale 1ns/1ps
`include "usb_defines.svh"

module tb_usb_list_unpack import usb_list_pkg::*; ;

    logic clk_i, rst_i, list_start_i, next_ready_i, dma_valid_i;
    logic [`USB_CBSR_W-1:0] cbsr_i;
    logic [`USB_ADDR_W-1:0] list_head_i, next_address_o, processed_ed_addr_o, current_ed_o;
    logic [`USB_WORD_W-1:0] dma_data_i, processed_head_p_o;
    list_kind_e  list_kind_i;
    fetch_kind_e next_kind_o;
    logic next_valid_o, dma_ready_o, processed_valid_o, current_ed_valid_o;
    logic list_done_o, ratio_reached_o;

    logic [127:0] mem [logic [27:0]];               // descriptor image with word 0 lowest
    bit           ed_ok [logic [27:0]];             // reachable EDs not fetched yet
    bit           td_ok [logic [27:0]];             // head TDs of active EDs
    logic [1:0]   kind_q [$];
    logic [27:0]  head_q [$];
    logic [1:0]   cbsr_q [$];
    logic [59:0]  wb_q [$];                         // {ed address, head_p}
    logic [27:0]  cur_q [$];
    bit           ratio_q [$];
    int unsigned  word_cnt = 0;
    int unsigned  err_cnt = 0;
    int unsigned  done_cnt = 0;
    logic [31:0]  lfsr_q = 32'hb93f;

    usb_clk_gen #(.period_ns(100)) u_clk (.clk_o(clk_i));

    usb_list_unpack_top u_usb_list_unpack_top (.*);

    // fibonacci lfsr with taps 32 22 2 1
    function logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function int unsigned rand_bits(int unsigned n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | lfsr_step();  // one step per bit
        return v;
    endfunction

    task automatic load_golden(output bit ok);
        int fd, n;
        string tag, line;
        logic [31:0] a, w0, w1, w2, w3;
        ok = 1'b0;
        fd = $fopen("tb/usb_list_unpack_golden.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) break;
            if (tag == "#") n = $fgets(line, fd);            // comment line
            else if (tag == "m") begin
                n = $fscanf(fd, "%h %h %h %h %h", a, w0, w1, w2, w3);
                mem[a[27:0]] = {w3, w2, w1, w0};
                word_cnt += 4;
            end else if (tag == "l") begin
                n = $fscanf(fd, "%h %h %h", w0, a, w1);
                kind_q.push_back(w0[1:0]);
                head_q.push_back(a[27:0]);
                cbsr_q.push_back(w1[1:0]);
            end else if (tag == "w") begin
                n = $fscanf(fd, "%h %h", a, w0);
                wb_q.push_back({a[27:0], w0});
            end else if (tag == "c") begin
                n = $fscanf(fd, "%h", a);
                cur_q.push_back(a[27:0]);
            end else if (tag == "r") begin
                n = $fscanf(fd, "%h", a);
                ratio_q.push_back(a[0]);
            end
        end
        $fclose(fd);
        ok = 1'b1;
    endtask

    // answers one fetch from the memory image at the edge that saw the request
    task automatic serve_fetch();
        logic [27:0]  addr;
        logic [127:0] desc;
        fetch_kind_e  kind;
        addr = next_address_o;
        kind = next_kind_o;
        assert (mem.exists(addr)) else begin
            err_cnt++;
            $display("[ERROR] %0t: fetch of %h outside the memory image", $time, addr);
        end
        desc = mem.exists(addr) ? mem[addr] : '0;
        if (kind == fetch_ed) begin
            assert (ed_ok.exists(addr)) else begin
                err_cnt++;
                $display("[ERROR] %0t: ED fetch %h not on the list chain", $time, addr);
            end
            ed_ok.delete(addr);                      // each ED once per walk
            if (desc[127:100] != '0) ed_ok[desc[127:100]] = 1'b1;   // next_ed
            // active when not skipped, not halted and HeadP != TailP
            if (!desc[14] && !desc[64] && desc[95:68] != desc[63:36]) td_ok[desc[95:68]] = 1'b1;
        end else begin
            assert (td_ok.exists(addr)) else begin
                err_cnt++;
                $display("[ERROR] %0t: TD fetch %h is no active HeadP", $time, addr);
            end
            td_ok.delete(addr);                      // one TD per active ED
        end
        repeat (rand_bits(2)) @(posedge clk_i);      // late ready
        #1 next_ready_i = 1'b1;
        @(posedge clk_i);
        #1 next_ready_i = 1'b0;
        for (int i = 0; i < `USB_DESC_WORDS; i++) begin
            dma_valid_i = 1'b0;
            repeat (rand_bits(2)) begin              // dma gap
                @(posedge clk_i);
                #1;
            end
            dma_valid_i = 1'b1;
            dma_data_i  = desc[i*32 +: 32];
            do @(posedge clk_i); while (!dma_ready_o);
            #1;
        end
        dma_valid_i = 1'b0;
    endtask

    // memory model
    initial begin
        forever begin
            @(posedge clk_i);
            if (!rst_i && next_valid_o) serve_fetch();
        end
    end

    // output monitor sampling on the rising edge
    always @(posedge clk_i) begin
        if (!rst_i && processed_valid_o) begin
            assert (wb_q.size() != 0) else begin
                err_cnt++;
                $display("unexpected write-back for ED %h at %0t", processed_ed_addr_o, $time);
            end
            if (wb_q.size() != 0) begin
                assert ({processed_ed_addr_o, processed_head_p_o} == wb_q[0]) else begin
                    err_cnt++;
                    $display("[ERROR] %0t: write-back %h/%h, expected %h/%h", $time,
                        processed_ed_addr_o, processed_head_p_o, wb_q[0][59:32], wb_q[0][31:0]);
                end
                void'(wb_q.pop_front());
            end
        end
        if (!rst_i && current_ed_valid_o) begin
            assert (cur_q.size() != 0 && current_ed_o == cur_q[0]) else begin
                err_cnt++;
                $display("[ERROR] %0t: current ED %h not the expected one", $time, current_ed_o);
            end
            if (cur_q.size() != 0) void'(cur_q.pop_front());
        end
        if (!rst_i && list_done_o) begin
            assert (ratio_q.size() != 0 && ratio_reached_o == ratio_q[0]) else begin
                err_cnt++;
                $display("[ERROR] %0t: ratio level %0b at end of list %0d is wrong", $time,
                    ratio_reached_o, done_cnt);
            end
            if (ratio_q.size() != 0) void'(ratio_q.pop_front());
            done_cnt++;
        end
    end

    // watchdog scaled by the size of the memory image
    initial begin
        wait (word_cnt != 0);
        repeat (400 * word_cnt) @(posedge clk_i);
        $display("watchdog expired before all lists finished");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic run_lists();
        int unsigned n_lists;
        n_lists = head_q.size();
        for (int i = 0; i < n_lists; i++) begin
            @(posedge clk_i);
            #1;
            ed_ok.delete();                          // a new walk starts at its head
            td_ok.delete();
            ed_ok[head_q[i]] = 1'b1;
            cbsr_i       = cbsr_q[i];
            list_head_i  = head_q[i];
            list_kind_i  = list_kind_e'(kind_q[i]);
            list_start_i = 1'b1;                     // one cycle pulse
            @(posedge clk_i);
            #1 list_start_i = 1'b0;
            while (done_cnt <= i) @(posedge clk_i);
            repeat (5) @(posedge clk_i);
        end
        repeat (20) @(posedge clk_i);                // any late pulse would show here
        assert (done_cnt == n_lists) else begin
            err_cnt++;
            $display("list done pulsed %0d times for %0d lists", done_cnt, n_lists);
        end
        assert (wb_q.size() == 0 && cur_q.size() == 0) else begin
            err_cnt++;
            $display("expected write-back or current ED records were never seen");
        end
    endtask

    initial begin
        bit ok;
        int unsigned fails;
        rst_i = 1'b1;
        cbsr_i = '0;
        list_start_i = 1'b0;
        list_head_i = '0;
        list_kind_i = list_control;
        next_ready_i = 1'b0;
        dma_data_i = '0;
        dma_valid_i = 1'b0;
        load_golden(ok);
        if (!ok) begin
            $display("cannot open the golden data file");
            $display("TESTS FAILED");
            $finish;
        end else begin
            repeat (5) @(posedge clk_i);             // reset held 5 cycles
            #1 rst_i = 1'b0;
            run_lists();
            fails = u_usb_list_unpack_top.u_list_assert.fail_cnt;
            $display("error counts: %0d check errors, %0d assertion failures", err_cnt, fails);
            if (err_cnt == 0 && fails == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/usb_ohci_pkg.sv
rtl/usb_list_pkg.sv
rtl/usb_desc_assembler.sv
rtl/usb_ed_queue.sv
rtl/usb_cb_ratio_counter.sv
rtl/usb_unpack_descriptors.sv
rtl/usb_list_unpack_top.sv
tb/usb_clk_gen.sv
tb/usb_list_unpack_assert.sv
tb/tb_usb_list_unpack.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_usb_list_unpack -f sim.f
	./obj_dir/Vtb_usb_list_unpack | tee sim.log
	@! grep -q "TESTS FAILED" sim.log
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/usb_list_unpack_golden.txt
# m: ed/td address (addr bits 31:4) then words 0..3 | l: list kind, head ED, cbsr
# w: ED address, new HeadP | c: current ED | r: ratio level at list end
m 0000100 00400001 00003000 00002002 00001100
m 0000110 00404001 00003000 00002a00 00001200
m 0000120 00400001 00003000 00002901 00001300
m 0000130 00400001 00003000 00003000 00001400
m 0000140 00400001 00003000 00002100 00000000
m 0000150 00400002 00003000 00002400 00000000
m 0000160 00400003 00003000 00002602 00001700
m 0000170 00400003 00003000 00002703 00000000
m 0000200 f0000000 00010000 00002200 000100ff
m 0000210 f0000000 00020000 00002300 000200ff
m 0000240 f0000000 00030000 00002500 000300ff
m 0000260 f0000000 00040000 00002800 000400ff
l 0 0000100 1
w 0000100 00002202
c 0000110
c 0000120
c 0000130
c 0000140
w 0000140 00002300
c 0000000
r 1
l 1 0000150 0
w 0000150 00002500
c 0000000
r 0
l 0 0000160 0
w 0000160 00002802
c 0000170
c 0000000
r 1
